//--- design/dataflowPkg.sv
package dataflowPkg;

    typedef logic [7:0]  byte_t;     // Internal bus or register value
    typedef logic [15:0] address_t;  // Program counter value

    localparam int CONTROL_WIDTH = 48;
    typedef logic [CONTROL_WIDTH-1:0] controlWord_t;

    // Bus drivers
    localparam int DB_FROM_ACC     = 0;
    localparam int DB_FROM_PCL     = 1;
    localparam int DB_FROM_PCH     = 2;
    localparam int DB_FROM_PSR     = 3;
    localparam int DB_FROM_DATA    = 4;
    localparam int SB_FROM_X       = 5;
    localparam int SB_FROM_Y       = 6;
    localparam int SB_FROM_SP      = 7;
    localparam int SB_FROM_ALU     = 8;
    localparam int SB_FROM_ACC     = 9;
    localparam int ADL_FROM_PCL    = 10;
    localparam int ADL_FROM_SP     = 11;
    localparam int ADL_FROM_ALU    = 12;
    localparam int ADL_FROM_DATA   = 13;
    localparam int ADL_ZERO        = 14;
    localparam int ADH_FROM_PCH    = 15;
    localparam int ADH_FROM_DATA   = 16;
    localparam int ADH_ZERO        = 17;

    localparam int BRIDGE_SB_DB    = 18;
    localparam int BRIDGE_SB_ADH   = 19;

    // Register loads, sampled on the next rising edge
    localparam int LOAD_X          = 20;
    localparam int LOAD_Y          = 21;
    localparam int LOAD_SP         = 22;
    localparam int LOAD_ACC        = 23;
    localparam int LOAD_ALU        = 24;
    localparam int LOAD_DOR        = 25;
    localparam int LOAD_ABL        = 26;
    localparam int LOAD_ABH        = 27;
    localparam int LOAD_PCL        = 28;
    localparam int LOAD_PCH        = 29;
    localparam int PC_INC          = 30;

    // ALU operand selects
    localparam int ALU_A_SB        = 31;
    localparam int ALU_A_ZERO      = 32;
    localparam int ALU_B_DB        = 33;
    localparam int ALU_B_NOT_DB    = 34;
    localparam int ALU_B_ADL       = 35;

    localparam int ALU_SUM         = 36;
    localparam int ALU_AND         = 37;
    localparam int ALU_EOR         = 38;
    localparam int ALU_OR          = 39;
    localparam int ALU_SHIFT_RIGHT = 40;
    localparam int ALU_CARRY_IN    = 41;

    localparam int PSR_FROM_DB     = 42;
    localparam int PSR_C_FROM_ALU  = 43;
    localparam int PSR_V_FROM_ALU  = 44;
    localparam int PSR_Z_FROM_DB   = 45;
    localparam int PSR_N_FROM_DB   = 46;
    // Bit 47 spare

    // Flag positions in the status byte
    localparam int PSR_C = 0;
    localparam int PSR_Z = 1;
    localparam int PSR_I = 2;
    localparam int PSR_D = 3;
    localparam int PSR_V = 6;
    localparam int PSR_N = 7;

endpackage

//--- design/busNetwork.sv
module busNetwork (
    input  dataflowPkg::controlWord_t control,
    input  dataflowPkg::byte_t        xValue,
    input  dataflowPkg::byte_t        yValue,
    input  dataflowPkg::byte_t        spValue,
    input  dataflowPkg::byte_t        accValue,
    input  dataflowPkg::byte_t        aluHoldValue,
    input  dataflowPkg::byte_t        dataLatch,
    input  dataflowPkg::byte_t        statusFlags,
    input  dataflowPkg::address_t     pcValue,
    output dataflowPkg::byte_t        dataBus,
    output dataflowPkg::byte_t        stackBus,
    output dataflowPkg::byte_t        addressLowBus,
    output dataflowPkg::byte_t        addressHighBus
);
    import dataflowPkg::*;

    byte_t pclValue;
    byte_t pchValue;
    byte_t dbRaw;   // Buses before the bridges
    byte_t sbRaw;
    byte_t adlRaw;
    byte_t adhRaw;
    byte_t dbMerged;
    byte_t sbMerged;
    byte_t commonValue;

    // An enabled source pulls bits low and a disabled one leaves the precharge
    function automatic byte_t pull(input logic enable, input byte_t value);
        return enable ? value : 8'hFF;
    endfunction

    assign pclValue = pcValue[7:0];
    assign pchValue = pcValue[15:8];

    always_comb begin
        dbRaw = 8'hFF;
        dbRaw &= pull(control[DB_FROM_ACC], accValue);
        dbRaw &= pull(control[DB_FROM_PCL], pclValue);
        dbRaw &= pull(control[DB_FROM_PCH], pchValue);
        dbRaw &= pull(control[DB_FROM_PSR], statusFlags);
        dbRaw &= pull(control[DB_FROM_DATA], dataLatch);

        sbRaw = 8'hFF;
        sbRaw &= pull(control[SB_FROM_X], xValue);
        sbRaw &= pull(control[SB_FROM_Y], yValue);
        sbRaw &= pull(control[SB_FROM_SP], spValue);
        sbRaw &= pull(control[SB_FROM_ALU], aluHoldValue);
        sbRaw &= pull(control[SB_FROM_ACC], accValue);

        adlRaw = 8'hFF;
        adlRaw &= pull(control[ADL_FROM_PCL], pclValue);
        adlRaw &= pull(control[ADL_FROM_SP], spValue);
        adlRaw &= pull(control[ADL_FROM_ALU], aluHoldValue);
        adlRaw &= pull(control[ADL_FROM_DATA], dataLatch);
        adlRaw &= pull(control[ADL_ZERO], 8'h00);  // Preset to 00

        adhRaw = 8'hFF;
        adhRaw &= pull(control[ADH_FROM_PCH], pchValue);
        adhRaw &= pull(control[ADH_FROM_DATA], dataLatch);
        adhRaw &= pull(control[ADH_ZERO], 8'h00);
    end

    // SB/DB bridge first and its result then meets ADH
    always_comb begin
        if (control[BRIDGE_SB_DB]) begin
            dbMerged = dbRaw & sbRaw;
            sbMerged = dbRaw & sbRaw;
        end else begin
            dbMerged = dbRaw;
            sbMerged = sbRaw;
        end

        commonValue = sbMerged & adhRaw;

        if (control[BRIDGE_SB_ADH]) begin
            stackBus       = commonValue;
            addressHighBus = commonValue;
            dataBus        = control[BRIDGE_SB_DB] ? commonValue : dbMerged;
        end else begin
            stackBus       = sbMerged;
            addressHighBus = adhRaw;
            dataBus        = dbMerged;
        end
    end

    assign addressLowBus = adlRaw;  // ADL has no bridge

endmodule

//--- design/programCounter.sv
module programCounter #(
    parameter dataflowPkg::address_t PC_RESET = 16'hFFFC
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  dataflowPkg::controlWord_t control,
    input  dataflowPkg::byte_t        addressLowBus,
    input  dataflowPkg::byte_t        addressHighBus,
    output dataflowPkg::address_t     pcValue
);
    import dataflowPkg::*;

    address_t loadedPc;
    address_t nextPc;

    // Halves load independently from the address buses
    always_comb begin
        loadedPc[7:0]  = control[LOAD_PCL] ? addressLowBus : pcValue[7:0];
        loadedPc[15:8] = control[LOAD_PCH] ? addressHighBus : pcValue[15:8];
    end

    // Full 16-bit add so the carry crosses into PCH
    assign nextPc = loadedPc + address_t'(control[PC_INC]);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcValue <= PC_RESET;
        end else begin
            pcValue <= nextPc;
        end
    end

endmodule

//--- design/registerFile.sv
module registerFile #(
    parameter dataflowPkg::byte_t SP_RESET = 8'hFD
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  dataflowPkg::controlWord_t control,
    input  dataflowPkg::byte_t        externalData,
    input  dataflowPkg::byte_t        dataBus,
    input  dataflowPkg::byte_t        stackBus,
    input  dataflowPkg::byte_t        addressLowBus,
    input  dataflowPkg::byte_t        addressHighBus,
    input  dataflowPkg::byte_t        aluResult,
    output dataflowPkg::byte_t        xValue,
    output dataflowPkg::byte_t        yValue,
    output dataflowPkg::byte_t        spValue,
    output dataflowPkg::byte_t        accValue,
    output dataflowPkg::byte_t        aluHoldValue,
    output dataflowPkg::byte_t        dataLatch,
    output dataflowPkg::byte_t        addressLow,
    output dataflowPkg::byte_t        addressHigh,
    output dataflowPkg::byte_t        dataOut
);
    import dataflowPkg::*;

    // Index and accumulator registers all load from SB
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            xValue   <= '0;
            yValue   <= '0;
            spValue  <= SP_RESET;
            accValue <= '0;
        end else begin
            if (control[LOAD_X]) xValue <= stackBus;
            if (control[LOAD_Y]) yValue <= stackBus;
            if (control[LOAD_SP]) spValue <= stackBus;
            if (control[LOAD_ACC]) accValue <= stackBus;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aluHoldValue <= '0;
        end else if (control[LOAD_ALU]) begin
            aluHoldValue <= aluResult;
        end
    end

    // Outward facing registers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dataOut     <= '0;
            addressLow  <= '0;
            addressHigh <= '0;
        end else begin
            if (control[LOAD_DOR]) dataOut <= dataBus;
            if (control[LOAD_ABL]) addressLow <= addressLowBus;
            if (control[LOAD_ABH]) addressHigh <= addressHighBus;
        end
    end

    // Input latch runs one cycle behind the pins
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dataLatch <= '0;
        end else begin
            dataLatch <= externalData;
        end
    end

endmodule

//--- design/alu.sv
module alu (
    input  dataflowPkg::controlWord_t control,
    input  dataflowPkg::byte_t        dataBus,
    input  dataflowPkg::byte_t        stackBus,
    input  dataflowPkg::byte_t        addressLowBus,
    output dataflowPkg::byte_t        aluResult,
    output logic                      carryOut,
    output logic                      overflowOut
);
    import dataflowPkg::*;

    byte_t      operandA;
    byte_t      operandB;
    logic [8:0] sumWide;  // Sum with carry in bit 8
    logic       carryIn;

    assign carryIn = control[ALU_CARRY_IN];

    // Operand inputs float high like the buses
    always_comb begin
        operandA = 8'hFF;
        if (control[ALU_A_SB]) operandA &= stackBus;
        if (control[ALU_A_ZERO]) operandA &= 8'h00;

        operandB = 8'hFF;
        if (control[ALU_B_DB]) operandB &= dataBus;
        if (control[ALU_B_NOT_DB]) operandB &= ~dataBus;
        if (control[ALU_B_ADL]) operandB &= addressLowBus;
    end

    assign sumWide = {1'b0, operandA} + {1'b0, operandB} + {8'b0, carryIn};

    always_comb begin
        aluResult   = 8'h00;
        carryOut    = 1'b0;
        overflowOut = 1'b0;
        if (control[ALU_SUM]) begin
            aluResult   = sumWide[7:0];
            carryOut    = sumWide[8];
            // Same input signs, different result sign
            overflowOut = (operandA[7] == operandB[7]) && (sumWide[7] != operandA[7]);
        end else if (control[ALU_AND]) begin
            aluResult = operandA & operandB;
        end else if (control[ALU_EOR]) begin
            aluResult = operandA ^ operandB;
        end else if (control[ALU_OR]) begin
            aluResult = operandA | operandB;
        end else if (control[ALU_SHIFT_RIGHT]) begin
            aluResult = {carryIn, operandA[7:1]};
            carryOut  = operandA[0];  // Bit 0 falls out
        end
    end

endmodule

//--- design/statusRegister.sv
module statusRegister (
    input  logic                      clk,
    input  logic                      arstN,
    input  dataflowPkg::controlWord_t control,
    input  dataflowPkg::byte_t        dataBus,
    input  logic                      carryOut,
    input  logic                      overflowOut,
    output dataflowPkg::byte_t        statusFlags
);
    import dataflowPkg::*;

    logic carryFlag;
    logic zeroFlag;
    logic interruptFlag;
    logic decimalFlag;
    logic overflowFlag;
    logic negativeFlag;

    // Later assignments win, so specific loads override the DB load
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            carryFlag     <= 1'b0;
            zeroFlag      <= 1'b0;
            interruptFlag <= 1'b0;
            decimalFlag   <= 1'b0;
            overflowFlag  <= 1'b0;
            negativeFlag  <= 1'b0;
        end else begin
            if (control[PSR_FROM_DB]) begin
                carryFlag     <= dataBus[PSR_C];
                zeroFlag      <= dataBus[PSR_Z];
                interruptFlag <= dataBus[PSR_I];
                decimalFlag   <= dataBus[PSR_D];
                overflowFlag  <= dataBus[PSR_V];
                negativeFlag  <= dataBus[PSR_N];
            end
            if (control[PSR_C_FROM_ALU]) carryFlag <= carryOut;
            if (control[PSR_V_FROM_ALU]) overflowFlag <= overflowOut;
            if (control[PSR_Z_FROM_DB]) zeroFlag <= (dataBus == 8'h00);
            if (control[PSR_N_FROM_DB]) negativeFlag <= dataBus[7];
        end
    end

    // Break and unused bits always read 1
    always_comb begin
        statusFlags        = 8'b0011_0000;
        statusFlags[PSR_C] = carryFlag;
        statusFlags[PSR_Z] = zeroFlag;
        statusFlags[PSR_I] = interruptFlag;
        statusFlags[PSR_D] = decimalFlag;
        statusFlags[PSR_V] = overflowFlag;
        statusFlags[PSR_N] = negativeFlag;
    end

endmodule

//--- design/internalDataflow.sv
module internalDataflow #(
    parameter dataflowPkg::byte_t    SP_RESET = 8'hFD,
    parameter dataflowPkg::address_t PC_RESET = 16'hFFFC
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  dataflowPkg::controlWord_t control,
    input  dataflowPkg::byte_t        externalData,
    output dataflowPkg::byte_t        addressLow,
    output dataflowPkg::byte_t        addressHigh,
    output dataflowPkg::byte_t        dataOut,
    output dataflowPkg::byte_t        statusFlags
);
    import dataflowPkg::*;

    // Stored values headed for the bus network
    byte_t    xValue;
    byte_t    yValue;
    byte_t    spValue;
    byte_t    accValue;
    byte_t    aluHoldValue;
    byte_t    dataLatch;
    address_t pcValue;

    // Resolved buses
    byte_t dataBus;
    byte_t stackBus;
    byte_t addressLowBus;
    byte_t addressHighBus;

    byte_t aluResult;
    logic  carryOut;
    logic  overflowOut;

    busNetwork buses (
        .control(control),
        .xValue(xValue),
        .yValue(yValue),
        .spValue(spValue),
        .accValue(accValue),
        .aluHoldValue(aluHoldValue),
        .dataLatch(dataLatch),
        .statusFlags(statusFlags),
        .pcValue(pcValue),
        .dataBus(dataBus),
        .stackBus(stackBus),
        .addressLowBus(addressLowBus),
        .addressHighBus(addressHighBus)
    );

    registerFile #(
        .SP_RESET(SP_RESET)
    ) registers (
        .clk(clk),
        .arstN(arstN),
        .control(control),
        .externalData(externalData),
        .dataBus(dataBus),
        .stackBus(stackBus),
        .addressLowBus(addressLowBus),
        .addressHighBus(addressHighBus),
        .aluResult(aluResult),
        .xValue(xValue),
        .yValue(yValue),
        .spValue(spValue),
        .accValue(accValue),
        .aluHoldValue(aluHoldValue),
        .dataLatch(dataLatch),
        .addressLow(addressLow),
        .addressHigh(addressHigh),
        .dataOut(dataOut)
    );

    programCounter #(
        .PC_RESET(PC_RESET)
    ) pc (
        .clk(clk),
        .arstN(arstN),
        .control(control),
        .addressLowBus(addressLowBus),
        .addressHighBus(addressHighBus),
        .pcValue(pcValue)
    );

    alu arithmetic (
        .control(control),
        .dataBus(dataBus),
        .stackBus(stackBus),
        .addressLowBus(addressLowBus),
        .aluResult(aluResult),
        .carryOut(carryOut),
        .overflowOut(overflowOut)
    );

    statusRegister psr (
        .clk(clk),
        .arstN(arstN),
        .control(control),
        .dataBus(dataBus),
        .carryOut(carryOut),
        .overflowOut(overflowOut),
        .statusFlags(statusFlags)
    );

endmodule

//--- verification/dataflow_assertions.sv
module dataflowAssertions (
    input logic                      clk,
    input logic                      arstN,
    input dataflowPkg::controlWord_t control,
    input dataflowPkg::byte_t        addressHigh,
    input dataflowPkg::byte_t        dataOut,
    input dataflowPkg::byte_t        statusFlags
);
    import dataflowPkg::*;

    int failCount = 0;  // Read by the testbench

    // ABH only moves one cycle after its load
    abhStableWithoutLoad: assert property (
        @(posedge clk) disable iff (!arstN)
        !$past(control[LOAD_ABH]) |-> $stable(addressHigh)
    ) else begin
        failCount++;
        $error("addressHigh changed without LOAD_ABH in the previous cycle");
    end

    dorStableWithoutLoad: assert property (
        @(posedge clk) disable iff (!arstN)
        !$past(control[LOAD_DOR]) |-> $stable(dataOut)
    ) else begin
        failCount++;
        $error("dataOut changed without LOAD_DOR in the previous cycle");
    end

    unusedBitHigh: assert property (@(posedge clk) statusFlags[5])
    else begin
        failCount++;
        $error("Status bit 5 read as 0");
    end

endmodule

bind internalDataflow dataflowAssertions assertionChecks (
    .clk(clk),
    .arstN(arstN),
    .control(control),
    .addressHigh(addressHigh),
    .dataOut(dataOut),
    .statusFlags(statusFlags)
);

//--- verification/dataflowChecker.sv
module dataflowChecker #(
    parameter dataflowPkg::byte_t    SP_RESET = 8'hFD,
    parameter dataflowPkg::address_t PC_RESET = 16'hFFFC
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  dataflowPkg::controlWord_t control,
    input  dataflowPkg::byte_t        externalData,
    input  dataflowPkg::byte_t        addressLow,
    input  dataflowPkg::byte_t        addressHigh,
    input  dataflowPkg::byte_t        dataOut,
    input  dataflowPkg::byte_t        statusFlags,
    output int                        errorCount
);
    import dataflowPkg::*;

    byte_t    regX;
    byte_t    regY;
    byte_t    regSp;
    byte_t    regAcc;
    byte_t    regHold;
    byte_t    regLatch;
    byte_t    regAbl;
    byte_t    regAbh;
    byte_t    regDor;
    byte_t    flags;  // Only bits 7:6 and 3:0 are kept
    address_t regPc;

    initial errorCount = 0;

    // One clock edge of the datapath rules
    task automatic step(input controlWord_t c);
        byte_t      db;
        byte_t      sb;
        byte_t      adl;
        byte_t      adh;
        byte_t      opA;
        byte_t      opB;
        byte_t      result;
        logic [8:0] sum;
        logic       carry;
        logic       overflow;
        byte_t      pcLow;
        byte_t      pcHigh;

        // Precharged to FF and pulled low by every enabled source
        db = (c[DB_FROM_ACC] ? regAcc : 8'hFF) & (c[DB_FROM_PCL] ? regPc[7:0] : 8'hFF)
            & (c[DB_FROM_PCH] ? regPc[15:8] : 8'hFF)
            & (c[DB_FROM_PSR] ? {flags[7:6], 2'b11, flags[3:0]} : 8'hFF)
            & (c[DB_FROM_DATA] ? regLatch : 8'hFF);
        sb = (c[SB_FROM_X] ? regX : 8'hFF) & (c[SB_FROM_Y] ? regY : 8'hFF)
            & (c[SB_FROM_SP] ? regSp : 8'hFF) & (c[SB_FROM_ALU] ? regHold : 8'hFF)
            & (c[SB_FROM_ACC] ? regAcc : 8'hFF);
        adl = (c[ADL_FROM_PCL] ? regPc[7:0] : 8'hFF) & (c[ADL_FROM_SP] ? regSp : 8'hFF)
            & (c[ADL_FROM_ALU] ? regHold : 8'hFF) & (c[ADL_FROM_DATA] ? regLatch : 8'hFF)
            & (c[ADL_ZERO] ? 8'h00 : 8'hFF);
        adh = (c[ADH_FROM_PCH] ? regPc[15:8] : 8'hFF) & (c[ADH_FROM_DATA] ? regLatch : 8'hFF)
            & (c[ADH_ZERO] ? 8'h00 : 8'hFF);

        if (c[BRIDGE_SB_DB]) begin
            db = db & sb;
            sb = db;
        end
        if (c[BRIDGE_SB_ADH]) begin
            adh = adh & sb;
            sb = adh;
            if (c[BRIDGE_SB_DB]) db = adh;  // All three share one value
        end

        opA = c[ALU_A_ZERO] ? 8'h00 : (c[ALU_A_SB] ? sb : 8'hFF);
        opB = (c[ALU_B_DB] ? db : 8'hFF) & (c[ALU_B_NOT_DB] ? ~db : 8'hFF)
            & (c[ALU_B_ADL] ? adl : 8'hFF);
        sum = {1'b0, opA} + {1'b0, opB} + 9'(c[ALU_CARRY_IN]);
        result   = 8'h00;
        carry    = 1'b0;
        overflow = 1'b0;
        if (c[ALU_SUM]) begin
            {carry, result} = sum;
            overflow = ~(opA[7] ^ opB[7]) & (opA[7] ^ result[7]);
        end else if (c[ALU_AND]) begin
            result = opA & opB;
        end else if (c[ALU_EOR]) begin
            result = opA ^ opB;
        end else if (c[ALU_OR]) begin
            result = opA | opB;
        end else if (c[ALU_SHIFT_RIGHT]) begin
            result = {c[ALU_CARRY_IN], opA[7:1]};
            carry  = opA[0];
        end

        if (c[PSR_FROM_DB]) flags = {db[7:6], 2'b00, db[3:0]};
        if (c[PSR_C_FROM_ALU]) flags[PSR_C] = carry;
        if (c[PSR_V_FROM_ALU]) flags[PSR_V] = overflow;
        if (c[PSR_Z_FROM_DB]) flags[PSR_Z] = (db == 8'h00);
        if (c[PSR_N_FROM_DB]) flags[PSR_N] = db[7];

        if (c[LOAD_X]) regX = sb;
        if (c[LOAD_Y]) regY = sb;
        if (c[LOAD_SP]) regSp = sb;
        if (c[LOAD_ACC]) regAcc = sb;
        if (c[LOAD_ALU]) regHold = result;
        if (c[LOAD_DOR]) regDor = db;
        if (c[LOAD_ABL]) regAbl = adl;
        if (c[LOAD_ABH]) regAbh = adh;

        // Load first, then increment across the page
        pcLow  = c[LOAD_PCL] ? adl : regPc[7:0];
        pcHigh = c[LOAD_PCH] ? adh : regPc[15:8];
        regPc  = {pcHigh, pcLow} + 16'(c[PC_INC]);

        regLatch = externalData;
    endtask

    task automatic compare(input string name, input byte_t actual, input byte_t expected);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s expected %h, got %h at time %0t", name, expected, actual,
                     $time);
        end
    endtask

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regX     = 8'h00;
            regY     = 8'h00;
            regSp    = SP_RESET;
            regAcc   = 8'h00;
            regHold  = 8'h00;
            regLatch = 8'h00;
            regAbl   = 8'h00;
            regAbh   = 8'h00;
            regDor   = 8'h00;
            flags    = 8'h00;
            regPc    = PC_RESET;
        end else begin
            step(control);
        end
    end

    // Midway through the cycle, outputs have settled
    always @(negedge clk) begin
        if (arstN) begin
            compare("addressLow", addressLow, regAbl);
            compare("addressHigh", addressHigh, regAbh);
            compare("dataOut", dataOut, regDor);
            compare("statusFlags", statusFlags, {flags[7:6], 2'b11, flags[3:0]});
        end
    end

endmodule

//--- verification/dataflowTb.sv
module dataflowTb;
    import dataflowPkg::*;

    localparam byte_t    SP_START = 8'hFD;
    localparam address_t PC_START = 16'hFFFC;

    localparam int RESET_CYCLES   = 16;
    localparam int DRAIN_CYCLES   = 2;  // Loads reach the outputs one edge later
    localparam int IDLE_CYCLES    = 4;
    localparam int BUS_ITERATIONS = 60;
    localparam int DATA_CYCLES    = 50;
    localparam int PC_ITERATIONS  = 20;
    localparam int ALU_OPERATIONS = 200;
    localparam int MIX_CYCLES     = 1000;
    localparam int TEST_CYCLES = IDLE_CYCLES + BUS_ITERATIONS * 2 + DATA_CYCLES
        + PC_ITERATIONS * 8 + ALU_OPERATIONS * 4 + MIX_CYCLES + 6 * DRAIN_CYCLES;
    localparam int CYCLE_LIMIT = RESET_CYCLES + TEST_CYCLES + 100;

    logic         clk;
    logic         arstN;
    controlWord_t control;
    byte_t        externalData;
    byte_t        addressLow;
    byte_t        addressHigh;
    byte_t        dataOut;
    byte_t        statusFlags;
    int           checkerErrors;
    int           cycleCount = 0;
    int           testsPassed = 0;
    int           testsFailed = 0;
    int           aluOps[5] = '{ALU_SUM, ALU_AND, ALU_EOR, ALU_OR, ALU_SHIFT_RIGHT};

    internalDataflow #(
        .SP_RESET(SP_START),
        .PC_RESET(PC_START)
    ) UUT (
        .clk(clk),
        .arstN(arstN),
        .control(control),
        .externalData(externalData),
        .addressLow(addressLow),
        .addressHigh(addressHigh),
        .dataOut(dataOut),
        .statusFlags(statusFlags)
    );

    dataflowChecker #(
        .SP_RESET(SP_START),
        .PC_RESET(PC_START)
    ) scoreboard (
        .clk(clk),
        .arstN(arstN),
        .control(control),
        .externalData(externalData),
        .addressLow(addressLow),
        .addressHigh(addressHigh),
        .dataOut(dataOut),
        .statusFlags(statusFlags),
        .errorCount(checkerErrors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic int errorTotal();
        return checkerErrors + UUT.assertionChecks.failCount;
    endfunction

    function automatic controlWord_t flag(input int index);
        return controlWord_t'(1) << index;
    endfunction

    // At most one operation, one A select and one B select
    function automatic controlWord_t randomWord();
        controlWord_t word;
        int           bSelects[3] = '{ALU_B_DB, ALU_B_NOT_DB, ALU_B_ADL};
        int           pick;
        word = controlWord_t'({$urandom, $urandom});
        foreach (aluOps[i]) word[aluOps[i]] = 1'b0;
        foreach (bSelects[i]) word[bSelects[i]] = 1'b0;
        word[ALU_A_SB]   = 1'b0;
        word[ALU_A_ZERO] = 1'b0;
        pick = $urandom_range(0, 5);
        if (pick < 5) word[aluOps[pick]] = 1'b1;
        pick = $urandom_range(0, 3);
        if (pick < 3) word[bSelects[pick]] = 1'b1;
        pick = $urandom_range(0, 2);
        if (pick == 0) word[ALU_A_SB] = 1'b1;
        if (pick == 1) word[ALU_A_ZERO] = 1'b1;
        return word;
    endfunction

    task automatic drive(input controlWord_t word, input byte_t data);
        @(posedge clk);
        #2;
        control      = word;
        externalData = data;
    endtask

    task automatic reportTest(input string name, input int startErrors);
        int found;
        repeat (DRAIN_CYCLES) drive('0, byte_t'($urandom));
        found = errorTotal() - startErrors;
        if (found == 0) begin
            testsPassed++;
            $display("Test %-20s passed", name);
        end else begin
            testsFailed++;
            $display("Test %-20s failed with %0d mismatches", name, found);
        end
    endtask

    task automatic resolveBuses();
        int           loads[4] = '{LOAD_X, LOAD_Y, LOAD_SP, LOAD_ACC};
        controlWord_t drivers;
        controlWord_t observe;
        controlWord_t word;
        drivers = flag(SB_FROM_X) | flag(SB_FROM_Y) | flag(SB_FROM_SP) | flag(SB_FROM_ACC)
            | flag(DB_FROM_ACC) | flag(ADL_FROM_SP) | flag(BRIDGE_SB_DB) | flag(BRIDGE_SB_ADH);
        observe = flag(LOAD_DOR) | flag(LOAD_ABL) | flag(LOAD_ABH);
        for (int i = 0; i < BUS_ITERATIONS; i++) begin
            // Latched byte reaches a register through the SB/DB bridge
            drive(flag(DB_FROM_DATA) | flag(BRIDGE_SB_DB) | flag(loads[$urandom_range(0, 3)]),
                  byte_t'($urandom));
            if (i % 10 == 0) word = observe;  // All buses left precharged
            else word = (controlWord_t'({$urandom, $urandom}) & drivers) | observe;
            drive(word, byte_t'($urandom));
        end
    endtask

    task automatic stepProgramCounter();
        controlWord_t count;
        count = flag(PC_INC) | flag(ADL_FROM_PCL) | flag(ADH_FROM_PCH) | flag(DB_FROM_PCL)
            | flag(LOAD_ABL) | flag(LOAD_ABH) | flag(LOAD_DOR);
        repeat (PC_ITERATIONS) begin
            drive('0, byte_t'($urandom));  // Page number
            // Low byte close to FF so five increments cross the page
            drive(flag(ADH_FROM_DATA) | flag(LOAD_PCH), 8'hFB + byte_t'($urandom_range(0, 4)));
            drive(flag(ADL_FROM_DATA) | flag(LOAD_PCL), byte_t'($urandom));
            repeat (5) drive(count, byte_t'($urandom));
        end
    endtask

    task automatic exerciseAlu();
        controlWord_t word;
        repeat (ALU_OPERATIONS) begin
            drive('0, byte_t'($urandom));
            drive(flag(DB_FROM_DATA) | flag(BRIDGE_SB_DB) | flag(LOAD_ACC), byte_t'($urandom));
            word = flag(SB_FROM_ACC) | flag(DB_FROM_DATA) | flag(aluOps[$urandom_range(0, 4)])
                | flag(LOAD_ALU) | flag(PSR_C_FROM_ALU) | flag(PSR_V_FROM_ALU);
            word |= flag(($urandom_range(0, 7) == 0) ? ALU_A_ZERO : ALU_A_SB);
            word |= flag(($urandom_range(0, 1) == 1) ? ALU_B_NOT_DB : ALU_B_DB);
            word[ALU_CARRY_IN] = 1'($urandom_range(0, 1));
            drive(word, byte_t'($urandom));
            drive(flag(ADL_FROM_ALU) | flag(LOAD_ABL), byte_t'($urandom));  // Hold to ABL
        end
    endtask

    initial begin
        int startErrors;
        void'($urandom(3));
        control      = '0;
        externalData = '0;
        arstN        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arstN = 1'b1;

        startErrors = errorTotal();
        repeat (IDLE_CYCLES) drive('0, 8'h00);
        reportTest("reset state", startErrors);

        startErrors = errorTotal();
        resolveBuses();
        reportTest("bus resolution", startErrors);

        startErrors = errorTotal();
        repeat (DATA_CYCLES) begin
            drive(flag(DB_FROM_DATA) | flag(ADL_FROM_DATA) | flag(ADH_FROM_DATA)
                  | flag(LOAD_DOR) | flag(LOAD_ABL) | flag(LOAD_ABH), byte_t'($urandom));
        end
        reportTest("external data path", startErrors);

        startErrors = errorTotal();
        stepProgramCounter();
        reportTest("program counter", startErrors);

        startErrors = errorTotal();
        exerciseAlu();
        reportTest("alu", startErrors);

        startErrors = errorTotal();
        repeat (MIX_CYCLES) drive(randomWord(), byte_t'($urandom));
        reportTest("random mix", startErrors);

        $display("Tests passed: %0d, failed: %0d, mismatches: %0d", testsPassed, testsFailed,
                 errorTotal());
        if (testsFailed == 0 && errorTotal() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
design/dataflowPkg.sv
design/busNetwork.sv
design/programCounter.sv
design/registerFile.sv
design/alu.sv
design/statusRegister.sv
design/internalDataflow.sv
verification/dataflow_assertions.sv
verification/dataflowChecker.sv
verification/dataflowTb.sv

//--- Bender.yml
package:
  name: internal_dataflow

sources:
  - design/dataflowPkg.sv
  - design/busNetwork.sv
  - design/programCounter.sv
  - design/registerFile.sv
  - design/alu.sv
  - design/statusRegister.sv
  - design/internalDataflow.sv
  - target: simulation
    files:
      - verification/dataflow_assertions.sv
      - verification/dataflowChecker.sv
      - verification/dataflowTb.sv
